// ==== hw/cpu_ctrl_params.svh ====
`ifndef CPU_CTRL_PARAMS_SVH
`define CPU_CTRL_PARAMS_SVH

// instruction and data word width
`define CPU_CTRL_DATA_W 32

// register file address width
`define CPU_CTRL_RADDR_W 4

// register used as stack pointer
`define CPU_CTRL_REG_SP 15

// microsequence step counter width
`define CPU_CTRL_SEQ_W 3

`endif

// ==== hw/cpu_ctrl_pkg.sv ====
`default_nettype none

`include "cpu_ctrl_params.svh"

package cpu_ctrl_pkg;

  typedef enum logic [1:0] {st_reset, st_exception, st_fetch, st_execute} ctrl_state_e;

  typedef enum logic [4:0] {
    i_nop, i_rts, i_rti, i_inc, i_dec, i_push, i_pop, i_cmp,
    i_mov, i_com, i_neg, i_mov_l, i_ext_b, i_ext, i_cli, i_sti,
    i_mov_b, i_alu_reg, i_alu_imm, i_branch, i_ldiu,
    i_st_l, i_ld_l, i_st_w, i_ld_w, i_st_b, i_ld_b,
    i_jmp, i_jsr, i_trap, i_illegal
  } instr_e;

  // low opcode bits of the immediate-mode branch group
  typedef enum logic [3:0] {
    br_always, br_eq, br_ne, br_gtu, br_gt, br_ge,
    br_le, br_lt, br_geu, br_ltu, br_leu, br_never
  } br_cond_e;

  // remaining codes come straight from the opcode
  typedef enum logic [2:0] {alu_add = 3'd2, alu_sub = 3'd3} alu_func_e;

  typedef enum logic [1:0] {alu2_reg, alu2_imm, alu2_four, alu2_one} alu2sel_e;

  typedef enum logic [2:0] {
    rs_alu, rs_mdr, rs_neg, rs_com, rs_mov, rs_uimm, rs_extb, rs_exth
  } regsel_e;

  typedef enum logic [3:0] {
    mdr_none = 4'h0, mdr_bus = 4'h1, mdr_rega = 4'h3, mdr_pc = 4'h6
  } mdrsel_e;

  typedef enum logic [1:0] {mar_none, mar_bus, mar_alu, mar_sp} marsel_e;

  typedef enum logic [2:0] {
    pc_hold, pc_inc, pc_mar, pc_rel, pc_alu, pc_vector
  } pcsel_e;

  typedef enum logic [1:0] {rw_none, rw_byte, rw_half, rw_long} reg_write_e;

  typedef struct packed {
    logic                          ir_write;
    logic [1:0]                    ccrsel;
    alu_func_e                     alu_func;
    alu2sel_e                      alu2sel;
    regsel_e                       regsel;
    logic [`CPU_CTRL_RADDR_W-1:0]  reg_read_addr1;
    logic [`CPU_CTRL_RADDR_W-1:0]  reg_read_addr2;
    logic [`CPU_CTRL_RADDR_W-1:0]  reg_write_addr;
    reg_write_e                    reg_write;
    mdrsel_e                       mdrsel;
    marsel_e                       marsel;
    pcsel_e                        pcsel;
    logic                          addrsel;  // 0 pc, 1 mar
    logic [3:0]                    byteenable;
    logic                          bus_cyc;
    logic                          bus_write;
  } ctrl_word_t;

endpackage

`default_nettype wire

// ==== hw/ctrl_decode_if.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_ctrl_params.svh"

interface ctrl_decode_if;
  import cpu_ctrl_pkg::*;

  instr_e                        op;
  br_cond_e                      cond;
  alu_func_e                     alu_func;
  logic [`CPU_CTRL_RADDR_W-1:0]  ra;
  logic [`CPU_CTRL_RADDR_W-1:0]  rb;
  logic [`CPU_CTRL_RADDR_W-1:0]  rc;
  logic [2:0]                    trap_code;

  modport dec (output op, cond, alu_func, ra, rb, rc, trap_code);

  modport user (input op, cond, alu_func, ra, rb, rc, trap_code);

endinterface

`default_nettype wire

// ==== hw/ctrl_status_if.sv ====
`default_nettype none
`timescale 1ns/1ns

interface ctrl_status_if;

  logic       ie_set;     // enable interrupts
  logic       ie_clr;     // disable interrupts
  logic       exc_load;   // one-cycle pulse
  logic [3:0] exc_code;

  logic       int_en;
  logic [3:0] exception;
  logic       irq_take;   // enabled and pending

  modport seq (
    output ie_set, ie_clr, exc_load, exc_code,
    input  int_en, exception, irq_take
  );

  modport regs (
    input  ie_set, ie_clr, exc_load, exc_code,
    output int_en, exception, irq_take
  );

endinterface

`default_nettype wire

// ==== hw/ctrl_decode.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_ctrl_params.svh"

module ctrl_decode (
  input  logic [`CPU_CTRL_DATA_W-1:0] ir,
  ctrl_decode_if.dec                  dif
);
  import cpu_ctrl_pkg::*;

  logic [1:0] mode;
  logic [6:0] op7;  // register mode
  logic [3:0] op4;  // indirect and immediate modes
  logic [5:0] op6;  // direct mode
  instr_e     op;

  assign mode = ir[31:30];
  assign op7  = ir[29:23];
  assign op4  = ir[29:26];
  assign op6  = ir[29:24];

  always_comb begin
    op = i_illegal;
    case (mode)
      2'b00: begin
        case (op7)
          7'h00: op = i_nop;
          7'h01: op = i_rts;
          7'h02: op = i_rti;
          7'h03: op = i_inc;
          7'h04: op = i_dec;
          7'h05: op = i_push;
          7'h06: op = i_pop;
          7'h09: op = i_cmp;
          7'h0a: op = i_mov;
          7'h0b: op = i_com;
          7'h0c: op = i_neg;
          7'h0f: op = i_mov_l;
          7'h12: op = i_ext_b;
          7'h13: op = i_ext;
          7'h14: op = i_cli;
          7'h15: op = i_sti;
          7'h16: op = i_mov_b;
          default: if (op7[6:4] == 3'b010) op = i_alu_reg;  // rA <= rB op rC
        endcase
      end
      2'b01: begin
        case (op4)
          4'h0: op = i_st_l;
          4'h1: op = i_ld_l;
          4'h2: op = i_st_w;
          4'h3: op = i_ld_w;
          4'h4: op = i_st_b;
          4'h5: op = i_ld_b;
          4'h9: op = i_jmp;
          4'ha: op = i_jsr;
          default: op = i_illegal;
        endcase
      end
      2'b10: begin
        if (op4 <= 4'hb)
          op = i_branch;  // bra .. brn
        else if (op4 == 4'hc)
          op = i_ldiu;
      end
      default: begin
        if (op6[5:4] == 2'b00)
          op = i_alu_imm;  // rA <= rB op imm
        else if (op6 == 6'h32)
          op = i_trap;
      end
    endcase
  end

  assign dif.op        = op;
  assign dif.cond      = br_cond_e'(op4);
  assign dif.alu_func  = alu_func_e'((mode == 2'b00) ? op7[2:0] : op6[2:0]);
  assign dif.ra        = ir[19:16];
  assign dif.rb        = ir[15:12];
  assign dif.rc        = ir[11:8];
  assign dif.trap_code = ir[2:0];

endmodule

`default_nettype wire

// ==== hw/ctrl_status.sv ====
`default_nettype none
`timescale 1ns/1ns

module ctrl_status (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [2:0]  interrupt,
  ctrl_status_if.regs sif
);

  logic       int_en_q;
  logic [3:0] exc_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      int_en_q <= 1'b0;
      exc_q    <= 4'h0;
    end else begin
      if (sif.ie_set)
        int_en_q <= 1'b1;
      else if (sif.ie_clr)
        int_en_q <= 1'b0;
      // load together with disable means an accepted interrupt
      if (sif.exc_load) begin
        if (sif.ie_clr)
          exc_q <= {1'b0, interrupt};
        else
          exc_q <= sif.exc_code;
      end
    end
  end

  assign sif.int_en    = int_en_q;
  assign sif.exception = exc_q;
  assign sif.irq_take  = int_en_q & (|interrupt);

endmodule

`default_nettype wire

// ==== hw/ctrl_branch.sv ====
`default_nettype none
`timescale 1ns/1ns

module ctrl_branch (
  input  logic [2:0]  ccr,
  ctrl_decode_if.user dif,
  output logic        take
);
  import cpu_ctrl_pkg::*;

  logic ltu;
  logic lt;
  logic eq;

  assign {ltu, lt, eq} = ccr;

  always_comb begin
    case (dif.cond)
      br_always: take = 1'b1;
      br_eq:     take = eq;
      br_ne:     take = ~eq;
      br_gt:     take = ~(lt | eq);
      br_ge:     take = ~lt;
      br_le:     take = lt | eq;
      br_lt:     take = lt;
      br_gtu:    take = ~(ltu | eq);
      br_geu:    take = ~ltu;
      br_ltu:    take = ltu;
      br_leu:    take = ltu | eq;
      default:   take = 1'b0;  // brn and unused codes
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/ctrl_microcode.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_ctrl_params.svh"

module ctrl_microcode (
  input  logic                     clk_i,
  input  logic                     rst_i,
  ctrl_decode_if.user              dif,
  ctrl_status_if.seq               sif,
  input  logic                     take,
  input  logic                     bus_ack,
  input  logic [1:0]               bus_align,
  output cpu_ctrl_pkg::ctrl_word_t cw
);
  import cpu_ctrl_pkg::*;

  localparam logic [`CPU_CTRL_RADDR_W-1:0] reg_sp = `CPU_CTRL_REG_SP;

  ctrl_state_e               state;
  ctrl_state_e               state_nxt;
  logic [`CPU_CTRL_SEQ_W-1:0] step;
  logic [`CPU_CTRL_SEQ_W-1:0] step_nxt;
  logic [3:0]                lanes;
  logic                      is_load;
  logic                      fin;       // last step, back to fetch
  logic                      wait_ack;  // bus step, hold until ack

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= st_reset;
      step  <= '0;
    end else begin
      state <= state_nxt;
      step  <= step_nxt;
    end
  end

  assign is_load = dif.op inside {i_ld_l, i_ld_w, i_ld_b};

  // lane 3 carries the lowest address
  always_comb begin
    case (dif.op)
      i_ld_w, i_st_w: lanes = bus_align[1] ? 4'b0011 : 4'b1100;
      i_ld_b, i_st_b: lanes = 4'b1000 >> bus_align;
      default:        lanes = 4'b1111;
    endcase
  end

  always_comb begin
    state_nxt         = state;
    step_nxt          = step + 1'b1;
    fin               = 1'b0;
    wait_ack          = 1'b0;
    sif.ie_set        = 1'b0;
    sif.ie_clr        = 1'b0;
    sif.exc_load      = 1'b0;
    sif.exc_code      = 4'h0;
    cw                = '0;
    cw.alu_func       = alu_add;
    cw.reg_read_addr1 = dif.ra;
    cw.reg_read_addr2 = dif.rb;
    cw.reg_write_addr = dif.ra;
    cw.byteenable     = 4'b1111;

    case (state)
      st_reset: begin
        state_nxt = st_exception;
        step_nxt  = '0;
      end
      st_exception: begin
        case (step)
          3'd0: begin
            if (sif.exception == 4'h0) begin
              step_nxt = 3'd3;  // reset entry, nothing to push
            end else begin
              cw.alu2sel        = alu2_four;  // sp - 4
              cw.alu_func       = alu_sub;
              cw.reg_read_addr1 = reg_sp;
              cw.mdrsel         = mdr_pc;
            end
          end
          3'd1: begin
            cw.marsel         = mar_alu;
            cw.reg_write_addr = reg_sp;
            cw.reg_write      = rw_long;
          end
          3'd2: begin
            cw.addrsel   = 1'b1;
            cw.bus_cyc   = 1'b1;
            cw.bus_write = 1'b1;
            wait_ack     = 1'b1;
          end
          3'd3: cw.pcsel = pc_vector;
          3'd4: begin
            cw.bus_cyc = 1'b1;
            cw.marsel  = mar_bus;  // handler address
            wait_ack   = 1'b1;
          end
          default: begin
            cw.pcsel = pc_mar;
            fin      = 1'b1;
          end
        endcase
      end
      st_fetch: begin
        if (step == '0) begin
          cw.bus_cyc  = 1'b1;
          cw.ir_write = 1'b1;
          if (sif.irq_take) begin
            state_nxt    = st_exception;
            step_nxt     = '0;
            sif.ie_clr   = 1'b1;
            sif.exc_load = 1'b1;
          end else begin
            wait_ack = 1'b1;
          end
        end else begin
          cw.pcsel  = pc_inc;
          state_nxt = st_execute;
          step_nxt  = '0;
        end
      end
      default: begin
        case (dif.op)
          i_nop: fin = 1'b1;
          i_rts, i_rti: begin
            case (step)
              3'd0: begin
                cw.reg_read_addr1 = reg_sp;
                cw.alu2sel        = alu2_four;  // sp + 4
                cw.marsel         = mar_sp;
                if (dif.op == i_rti) begin
                  sif.ie_set   = 1'b1;
                  sif.exc_load = 1'b1;  // back to code 0
                end
              end
              3'd1: begin
                cw.reg_write      = rw_long;
                cw.reg_write_addr = reg_sp;
                cw.pcsel          = pc_mar;  // pc addresses the stack
              end
              3'd2: begin
                cw.marsel  = mar_bus;
                cw.bus_cyc = 1'b1;
                wait_ack   = 1'b1;
              end
              default: begin
                cw.pcsel = pc_mar;
                fin      = 1'b1;
              end
            endcase
          end
          i_inc, i_dec, i_cmp: begin
            if (dif.op != i_inc)
              cw.alu_func = alu_sub;
            if (step == '0) begin
              if (dif.op != i_cmp)
                cw.alu2sel = alu2_one;
            end else begin
              if (dif.op == i_cmp)
                cw.ccrsel = 2'h1;
              else
                cw.reg_write = rw_long;
              fin = 1'b1;
            end
          end
          i_push: begin
            case (step)
              3'd0: begin
                cw.alu2sel        = alu2_four;
                cw.alu_func       = alu_sub;
                cw.reg_read_addr1 = reg_sp;
              end
              3'd1: begin
                cw.marsel         = mar_alu;
                cw.mdrsel         = mdr_rega;
                cw.reg_write_addr = reg_sp;
                cw.reg_write      = rw_long;
              end
              3'd2: begin
                cw.addrsel   = 1'b1;
                cw.bus_cyc   = 1'b1;
                cw.bus_write = 1'b1;
                wait_ack     = 1'b1;
              end
              default: fin = 1'b1;
            endcase
          end
          i_pop: begin
            cw.addrsel = 1'b1;
            case (step)
              3'd0: begin
                cw.marsel         = mar_sp;
                cw.alu2sel        = alu2_four;
                cw.reg_read_addr1 = reg_sp;
              end
              3'd1: begin
                cw.reg_write      = rw_long;
                cw.reg_write_addr = reg_sp;
              end
              3'd2: begin
                cw.bus_cyc = 1'b1;
                cw.mdrsel  = mdr_bus;
                wait_ack   = 1'b1;
              end
              default: begin
                cw.regsel    = rs_mdr;
                cw.reg_write = rw_long;
                fin          = 1'b1;
              end
            endcase
          end
          i_mov, i_mov_b, i_mov_l, i_com, i_neg, i_ext, i_ext_b, i_ldiu: begin
            cw.reg_write = rw_long;
            fin          = 1'b1;
            case (dif.op)
              i_mov: begin
                cw.regsel    = rs_mov;
                cw.reg_write = rw_half;
              end
              i_mov_b: begin
                cw.regsel    = rs_mov;
                cw.reg_write = rw_byte;
              end
              i_mov_l: cw.regsel = rs_mov;
              i_com:   cw.regsel = rs_com;
              i_neg:   cw.regsel = rs_neg;
              i_ext:   cw.regsel = rs_exth;
              i_ext_b: cw.regsel = rs_extb;
              default: cw.regsel = rs_uimm;  // ldiu
            endcase
          end
          i_cli: begin
            sif.ie_clr = 1'b1;
            fin        = 1'b1;
          end
          i_sti: begin
            sif.ie_set = 1'b1;
            fin        = 1'b1;
          end
          i_alu_reg, i_alu_imm: begin
            cw.alu_func       = dif.alu_func;
            cw.reg_read_addr1 = dif.rb;
            if (dif.op == i_alu_reg)
              cw.reg_read_addr2 = dif.rc;
            else
              cw.alu2sel = alu2_imm;
            if (step != '0) begin
              cw.reg_write = rw_long;
              fin          = 1'b1;
            end
          end
          i_branch: begin
            if (take)
              cw.pcsel = pc_rel;
            fin = 1'b1;
          end
          i_ld_l, i_ld_w, i_ld_b, i_st_l, i_st_w, i_st_b: begin
            cw.addrsel = 1'b1;
            case (step)
              3'd0: begin
                cw.reg_read_addr1 = dif.rb;
                cw.alu2sel        = alu2_imm;  // rB + offset
              end
              3'd1: begin
                cw.marsel = mar_alu;
                if (!is_load)
                  cw.mdrsel = mdr_rega;
              end
              3'd2: begin
                cw.bus_cyc    = 1'b1;
                cw.bus_write  = ~is_load;
                cw.byteenable = lanes;
                if (is_load)
                  cw.mdrsel = mdr_bus;
                wait_ack = 1'b1;
              end
              3'd3: begin
                if (is_load) begin
                  cw.regsel    = rs_mdr;
                  cw.reg_write = rw_long;
                end else begin
                  fin = 1'b1;
                end
              end
              default: fin = 1'b1;
            endcase
          end
          i_jmp, i_jsr: begin
            case (step)
              3'd0: begin
                cw.reg_read_addr1 = dif.rb;
                cw.alu2sel        = alu2_imm;
              end
              3'd1: begin
                cw.pcsel = pc_alu;
                if (dif.op == i_jmp) begin
                  fin = 1'b1;
                end else begin
                  cw.alu2sel        = alu2_four;  // sp - 4, mdr keeps return pc
                  cw.alu_func       = alu_sub;
                  cw.reg_read_addr1 = reg_sp;
                  cw.mdrsel         = mdr_pc;
                end
              end
              3'd2: begin
                cw.marsel         = mar_alu;
                cw.reg_write_addr = reg_sp;
                cw.reg_write      = rw_long;
              end
              3'd3: begin
                cw.addrsel   = 1'b1;
                cw.bus_cyc   = 1'b1;
                cw.bus_write = 1'b1;
                wait_ack     = 1'b1;
              end
              default: fin = 1'b1;
            endcase
          end
          i_trap: begin
            sif.exc_load = 1'b1;
            sif.exc_code = {1'b1, dif.trap_code};  // software traps are 8..15
            state_nxt    = st_exception;
            step_nxt     = '0;
          end
          default: begin
            sif.exc_load = 1'b1;
            sif.exc_code = 4'h3;  // bad opcode
            state_nxt    = st_exception;
            step_nxt     = '0;
          end
        endcase
      end
    endcase

    if (fin) begin
      state_nxt = st_fetch;
      step_nxt  = '0;
    end
    if (wait_ack && !bus_ack) begin
      state_nxt = state;
      step_nxt  = step;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cpu_control.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cpu_ctrl_params.svh"

module cpu_control (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`CPU_CTRL_DATA_W-1:0] ir,
  input  logic [2:0]                  ccr,
  input  logic                        bus_ack,
  input  logic [2:0]                  interrupt,
  input  logic [1:0]                  bus_align,
  output logic                        ir_write,
  output logic [1:0]                  ccrsel,
  output logic [2:0]                  alu_func,
  output logic [1:0]                  alu2sel,
  output logic [2:0]                  regsel,
  output logic [3:0]                  reg_read_addr1,
  output logic [3:0]                  reg_read_addr2,
  output logic [3:0]                  reg_write_addr,
  output logic [1:0]                  reg_write,
  output logic [3:0]                  mdrsel,
  output logic [1:0]                  marsel,
  output logic [2:0]                  pcsel,
  output logic                        addrsel,
  output logic [3:0]                  byteenable,
  output logic                        bus_cyc,
  output logic                        bus_write,
  output logic                        int_en,
  output logic [3:0]                  exception
);
  import cpu_ctrl_pkg::*;

  ctrl_decode_if dif ();
  ctrl_status_if sif ();

  ctrl_word_t cw;
  logic       take;

  ctrl_decode i_decode (.ir(ir), .dif(dif));

  ctrl_status i_status (.clk_i(clk_i), .rst_i(rst_i), .interrupt(interrupt), .sif(sif));

  ctrl_branch i_branch (.ccr(ccr), .dif(dif), .take(take));

  ctrl_microcode i_microcode (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .dif       (dif),
    .sif       (sif),
    .take      (take),
    .bus_ack   (bus_ack),
    .bus_align (bus_align),
    .cw        (cw)
  );

  // control word onto the datapath ports
  assign ir_write       = cw.ir_write;
  assign ccrsel         = cw.ccrsel;
  assign alu_func       = cw.alu_func;
  assign alu2sel        = cw.alu2sel;
  assign regsel         = cw.regsel;
  assign reg_read_addr1 = cw.reg_read_addr1;
  assign reg_read_addr2 = cw.reg_read_addr2;
  assign reg_write_addr = cw.reg_write_addr;
  assign reg_write      = cw.reg_write;
  assign mdrsel         = cw.mdrsel;
  assign marsel         = cw.marsel;
  assign pcsel          = cw.pcsel;
  assign addrsel        = cw.addrsel;
  assign byteenable     = cw.byteenable;
  assign bus_cyc        = cw.bus_cyc;
  assign bus_write      = cw.bus_write;
  assign int_en         = sif.int_en;
  assign exception      = sif.exception;

endmodule

`default_nettype wire

// ==== sim/tb_cpu_control.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_cpu_control;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] ir;
  logic [2:0]  ccr;
  logic        bus_ack;
  logic [2:0]  interrupt;
  logic [1:0]  bus_align;
  logic        ir_write;
  logic [1:0]  ccrsel;
  logic [2:0]  alu_func;
  logic [1:0]  alu2sel;
  logic [2:0]  regsel;
  logic [3:0]  reg_read_addr1;
  logic [3:0]  reg_read_addr2;
  logic [3:0]  reg_write_addr;
  logic [1:0]  reg_write;
  logic [3:0]  mdrsel;
  logic [1:0]  marsel;
  logic [2:0]  pcsel;
  logic        addrsel;
  logic [3:0]  byteenable;
  logic        bus_cyc;
  logic        bus_write;
  logic        int_en;
  logic [3:0]  exception;
  logic [31:0] rng;
  int unsigned cycles = 0;

  cpu_control i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // roughly 600 cycles of tests, so this leaves a wide margin
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("timeout: the tests did not finish within 3000 cycles");
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // ccr is {ltu, lt, eq}
  function automatic logic branch_taken(input logic [3:0] cond, input logic [2:0] c);
    case (cond)
      4'd0:    return 1'b1;
      4'd1:    return c[0];
      4'd2:    return !c[0];
      4'd3:    return !(c[2] || c[0]);
      4'd4:    return !(c[1] || c[0]);
      4'd5:    return !c[1];
      4'd6:    return c[1] || c[0];
      4'd7:    return c[1];
      4'd8:    return !c[2];
      4'd9:    return c[2];
      4'd10:   return c[2] || c[0];
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] enc_reg(input logic [6:0] op, input logic [3:0] ra,
                                          input logic [3:0] rb, input logic [3:0] rc);
    return {2'b00, op, 3'b000, ra, rb, rc, 8'h00};
  endfunction

  function automatic logic [31:0] enc_mid(input logic [1:0] mode, input logic [3:0] op,
                                          input logic [3:0] ra, input logic [3:0] rb);
    return {mode, op, 6'h00, ra, rb, 12'h000};
  endfunction

  function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [3:0] ra,
                                          input logic [3:0] rb, input logic [2:0] low);
    return {2'b11, op, 4'h0, ra, rb, 9'h000, low};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // one bus step, ack withheld for 0..3 cycles
  task automatic bus_step(input logic w, input logic [3:0] be, input logic adr,
                          input logic irw);
    int unsigned wait_n;
    wait_n = draw() % 4;
    for (int i = 0; i <= wait_n; i++) begin
      bus_ack = (i == wait_n);
      #8;
      check_eq("bus_cyc", bus_cyc, 1);
      check_eq("bus_write", bus_write, w);
      check_eq("byteenable", byteenable, be);
      check_eq("addrsel", addrsel, adr);
      check_eq("ir_write", ir_write, irw);
      next_cycle();
    end
    bus_ack = 1'b0;
  endtask

  task automatic fetch(input logic [31:0] instr);
    ir = instr;
    bus_step(1'b0, 4'hf, 1'b0, 1'b1);
    #8;
    check_eq("pcsel", pcsel, 1);
    check_eq("ir_write", ir_write, 0);
    check_eq("bus_cyc", bus_cyc, 0);
    next_cycle();
  endtask

  task automatic vector_tail();
    #8;
    check_eq("pcsel", pcsel, 5);
    next_cycle();
    bus_step(1'b0, 4'hf, 1'b0, 1'b0);
    #8;
    check_eq("pcsel", pcsel, 2);
    next_cycle();
  endtask

  task automatic exception_entry(input logic [3:0] code);
    #8;
    check_eq("exception", exception, code);
    check_eq("int_en", int_en, 0);
    check_eq("alu_func", alu_func, 3);
    check_eq("alu2sel", alu2sel, 2);
    check_eq("reg_read_addr1", reg_read_addr1, 15);
    check_eq("mdrsel", mdrsel, 6);
    next_cycle();
    #8;
    check_eq("marsel", marsel, 2);
    check_eq("reg_write_addr", reg_write_addr, 15);
    check_eq("reg_write", reg_write, 3);
    next_cycle();
    bus_step(1'b1, 4'hf, 1'b1, 1'b0);
    vector_tail();
  endtask

  task automatic test_reset();
    #8;
    check_eq("int_en", int_en, 0);
    check_eq("exception", exception, 0);
    check_eq("bus_cyc", bus_cyc, 0);
    check_eq("bus_write", bus_write, 0);
    check_eq("ir_write", ir_write, 0);
    check_eq("reg_write", reg_write, 0);
    next_cycle();
    #8;
    check_eq("pcsel", pcsel, 0);
    check_eq("bus_cyc", bus_cyc, 0);
    next_cycle();
    vector_tail();
  endtask

  task automatic test_alu();
    logic [31:0] r;
    logic [2:0]  f;
    logic [6:0]  op;
    for (int i = 0; i < 11; i++) begin
      r = draw();
      f = r[2:0];
      op = (i < 8) ? (7'h20 | 7'(f)) : ((i == 8) ? 7'h03 : ((i == 9) ? 7'h04 : 7'h09));
      if (i == 8)
        f = 3'd2;  // inc adds
      else if (i > 8)
        f = 3'd3;  // dec and cmp subtract
      fetch(enc_reg(op, r[11:8], r[15:12], r[19:16]));
      #8;
      check_eq("alu_func", alu_func, f);
      check_eq("reg_read_addr1", reg_read_addr1, (i < 8) ? r[15:12] : r[11:8]);
      check_eq("reg_read_addr2", reg_read_addr2, (i < 8) ? r[19:16] : r[15:12]);
      check_eq("alu2sel", alu2sel, (i == 8 || i == 9) ? 3 : 0);
      check_eq("reg_write", reg_write, 0);
      next_cycle();
      #8;
      check_eq("reg_write_addr", reg_write_addr, r[11:8]);
      check_eq("reg_write", reg_write, (i == 10) ? 0 : 3);
      check_eq("ccrsel", ccrsel, (i == 10) ? 1 : 0);
      next_cycle();
      if (i < 8) begin
        fetch(enc_imm(6'(f), r[11:8], r[15:12], 3'd0));
        #8;
        check_eq("alu_func", alu_func, f);
        check_eq("alu2sel", alu2sel, 1);
        check_eq("reg_read_addr1", reg_read_addr1, r[15:12]);
        next_cycle();
        #8;
        check_eq("reg_write", reg_write, 3);
        next_cycle();
      end
    end
  endtask

  task automatic test_moves();
    logic [31:0] r;
    logic [6:0]  ops [8];
    logic [2:0]  sel [8];
    logic [1:0]  wr [8];
    ops = '{7'h0a, 7'h16, 7'h0f, 7'h0b, 7'h0c, 7'h13, 7'h12, 7'h00};
    sel = '{3'd4, 3'd4, 3'd4, 3'd3, 3'd2, 3'd7, 3'd6, 3'd5};
    wr  = '{2'd2, 2'd1, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3};
    for (int i = 0; i < 8; i++) begin
      r = draw();
      if (i == 7)
        fetch(enc_mid(2'b10, 4'hc, r[3:0], r[7:4]));  // ldiu
      else
        fetch(enc_reg(ops[i], r[3:0], r[7:4], r[11:8]));
      #8;
      check_eq("regsel", regsel, sel[i]);
      check_eq("reg_write", reg_write, wr[i]);
      check_eq("reg_write_addr", reg_write_addr, r[3:0]);
      next_cycle();
    end
  endtask

  task automatic test_branches();
    logic [31:0] r;
    for (int i = 0; i < 36; i++) begin
      r = draw();
      ccr = r[2:0];
      fetch(enc_mid(2'b10, 4'(i % 12), 4'h0, 4'h0));
      #8;
      check_eq("pcsel", pcsel, branch_taken(4'(i % 12), r[2:0]) ? 3 : 0);
      next_cycle();
    end
  endtask

  task automatic test_mem();
    logic [31:0] r;
    logic [3:0]  lanes;
    logic        load;
    for (int op = 0; op < 6; op++) begin
      for (int al = 0; al < 4; al++) begin
        r = draw();
        load = op[0];
        bus_align = 2'(al);
        if (op < 2) begin
          lanes = 4'hf;
        end else if (op < 4) begin
          lanes = (al < 2) ? 4'b1100 : 4'b0011;  // upper half-word sits on the low lanes
        end else begin
          case (al)
            0:       lanes = 4'b1000;  // lowest byte address on lane 3
            1:       lanes = 4'b0100;
            2:       lanes = 4'b0010;
            default: lanes = 4'b0001;
          endcase
        end
        fetch(enc_mid(2'b01, 4'(op), r[3:0], r[7:4]));
        #8;
        check_eq("reg_read_addr1", reg_read_addr1, r[7:4]);
        check_eq("alu2sel", alu2sel, 1);
        next_cycle();
        #8;
        check_eq("marsel", marsel, 2);
        check_eq("mdrsel", mdrsel, load ? 0 : 3);
        next_cycle();
        bus_step(!load, lanes, 1'b1, 1'b0);
        #8;
        check_eq("reg_write", reg_write, load ? 3 : 0);
        check_eq("bus_cyc", bus_cyc, 0);
        next_cycle();
        if (load) begin
          #8;
          check_eq("reg_write", reg_write, 0);
          next_cycle();
        end
      end
    end
  endtask

  task automatic stack_pop_steps(input logic adr);
    #8;
    check_eq("reg_read_addr1", reg_read_addr1, 15);
    check_eq("marsel", marsel, 3);
    next_cycle();
    #8;
    check_eq("reg_write_addr", reg_write_addr, 15);
    check_eq("reg_write", reg_write, 3);
    next_cycle();
    bus_step(1'b0, 4'hf, adr, 1'b0);
  endtask

  task automatic test_stack();
    logic [31:0] r;
    r = draw();
    fetch(enc_reg(7'h05, r[3:0], 4'h0, 4'h0));  // push
    #8;
    check_eq("reg_read_addr1", reg_read_addr1, 15);
    check_eq("alu_func", alu_func, 3);
    next_cycle();
    #8;
    check_eq("reg_write_addr", reg_write_addr, 15);
    check_eq("mdrsel", mdrsel, 3);
    next_cycle();
    bus_step(1'b1, 4'hf, 1'b1, 1'b0);
    #8;
    check_eq("reg_write", reg_write, 0);
    next_cycle();
    fetch(enc_reg(7'h06, r[3:0], 4'h0, 4'h0));  // pop
    stack_pop_steps(1'b1);
    #8;
    check_eq("reg_write_addr", reg_write_addr, r[3:0]);
    check_eq("regsel", regsel, 1);
    next_cycle();
    fetch(enc_mid(2'b01, 4'ha, 4'h0, r[7:4]));  // jsr
    #8;
    check_eq("reg_read_addr1", reg_read_addr1, r[7:4]);
    next_cycle();
    #8;
    check_eq("pcsel", pcsel, 4);
    check_eq("reg_read_addr1", reg_read_addr1, 15);
    check_eq("mdrsel", mdrsel, 6);
    next_cycle();
    #8;
    check_eq("reg_write_addr", reg_write_addr, 15);
    next_cycle();
    bus_step(1'b1, 4'hf, 1'b1, 1'b0);
    #8;
    check_eq("bus_cyc", bus_cyc, 0);
    next_cycle();
    fetch(enc_reg(7'h01, 4'h0, 4'h0, 4'h0));  // rts
    stack_pop_steps(1'b0);
    #8;
    check_eq("pcsel", pcsel, 2);
    next_cycle();
    fetch(enc_mid(2'b01, 4'h9, 4'h0, r[7:4]));  // jmp
    next_cycle();
    #8;
    check_eq("pcsel", pcsel, 4);
    next_cycle();
  endtask

  task automatic test_exceptions();
    logic [31:0] r;
    r = draw();
    fetch(enc_imm(6'h32, 4'h0, 4'h0, r[2:0]));  // trap
    next_cycle();
    exception_entry(4'h8 + 4'(r[2:0]));
    fetch(enc_reg(7'h07, 4'h0, 4'h0, 4'h0));  // dropped opcode
    next_cycle();
    exception_entry(4'h3);
    fetch(enc_reg(7'h15, 4'h0, 4'h0, 4'h0));  // sti
    #8;
    check_eq("int_en", int_en, 0);
    next_cycle();
    interrupt = 3'd5;
    #8;
    check_eq("int_en", int_en, 1);
    check_eq("ir_write", ir_write, 1);
    next_cycle();
    interrupt = 3'd0;
    exception_entry(4'h5);
    fetch(enc_reg(7'h02, 4'h0, 4'h0, 4'h0));  // rti
    next_cycle();
    #8;
    check_eq("int_en", int_en, 1);
    check_eq("exception", exception, 0);
    check_eq("pcsel", pcsel, 2);
    next_cycle();
    bus_step(1'b0, 4'hf, 1'b0, 1'b0);
    next_cycle();
    fetch(enc_reg(7'h14, 4'h0, 4'h0, 4'h0));  // cli
    next_cycle();
  endtask

  initial begin
    rst_i     = 1'b1;
    ir        = 32'h0;
    ccr       = 3'h0;
    bus_ack   = 1'b0;
    interrupt = 3'h0;
    bus_align = 2'h0;
    rng       = 32'h73157aa1;
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    test_reset();
    test_alu();
    test_moves();
    test_branches();
    test_mem();
    test_stack();
    test_exceptions();
    #8;
    check_eq("ir_write", ir_write, 1);
    check_eq("int_en", int_en, 0);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_control.f ====
+incdir+hw
hw/cpu_ctrl_pkg.sv
hw/ctrl_decode_if.sv
hw/ctrl_status_if.sv
hw/ctrl_decode.sv
hw/ctrl_status.sv
hw/ctrl_branch.sv
hw/ctrl_microcode.sv
hw/cpu_control.sv
sim/tb_cpu_control.sv

// ==== Makefile ====
TOP = tb_cpu_control

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cpu_control.f --top-module cpu_control

sim:
	verilator --binary --timing -f cpu_control.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
